// File: all.f
rtl/soc_pkg.sv
rtl/host_packet_rx.sv
rtl/soc_ctrl.sv
rtl/data_mem.sv
rtl/code_mem.sv
rtl/io_regs.sv
rtl/soc_top.sv
testbench/tb_soc_top.sv

// File: Bender.yml
package:
  name: soc_fabric

sources:
  - rtl/soc_pkg.sv
  - rtl/host_packet_rx.sv
  - rtl/soc_ctrl.sv
  - rtl/data_mem.sv
  - rtl/code_mem.sv
  - rtl/io_regs.sv
  - rtl/soc_top.sv
  - target: test
    files:
      - testbench/tb_soc_top.sv

// File: testbench/tb_soc_top.sv
/* plays host (byte stream) and processor (buses) against a table of expected values
   inputs change on the falling edge, outputs are sampled on the next falling edge */
module tb_soc_top;
  import soc_pkg::*;

  localparam int DEPTH_I = 12;
  localparam logic [3:0] K_HOST = 4'd0;
  localparam logic [3:0] K_BAD_START = 4'd1;
  localparam logic [3:0] K_BAD_END = 4'd2;
  localparam logic [3:0] K_CPU_WR = 4'd3;
  localparam logic [3:0] K_RD_A = 4'd4;
  localparam logic [3:0] K_RD_B = 4'd5;
  localparam logic [3:0] K_PC = 4'd6;
  localparam logic [3:0] K_SYS = 4'd7;
  localparam logic [3:0] K_LED = 4'd8;
  localparam logic [3:0] K_TIMER = 4'd9;
  localparam logic [3:0] K_IDLE = 4'd10;

  typedef struct packed {
    logic [3:0]         kind;
    logic [DEPTH_V-1:0] addr;
    logic [WIDTH_D-1:0] data;
    logic [WIDTH_D-1:0] exp;
  } entry_t;

  logic clk = 1'b0;
  logic arst_n;
  logic rx_re;
  logic [7:0] rx_data;
  bus_wr_t cpu_wr;
  logic [DEPTH_V-1:0] cpu_addr_a;
  logic [DEPTH_V-1:0] cpu_addr_b;
  logic [DEPTH_I-1:0] cpu_pc;
  logic [WIDTH_D-1:0] cpu_rd_a;
  logic [WIDTH_D-1:0] cpu_rd_b;
  logic [WIDTH_I-1:0] cpu_instr;
  logic cpu_reset;
  logic cpu_resume;
  logic [LED_BITS-1:0] led;

  integer seed = 32'h25b8_a533;
  entry_t table_q [$];

  soc_top #(
    .DEPTH_I (DEPTH_I),
    .DEPTH_D (12)
  ) dut_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .rx_re      (rx_re),
    .rx_data    (rx_data),
    .cpu_wr     (cpu_wr),
    .cpu_addr_a (cpu_addr_a),
    .cpu_addr_b (cpu_addr_b),
    .cpu_pc     (cpu_pc),
    .cpu_rd_a   (cpu_rd_a),
    .cpu_rd_b   (cpu_rd_b),
    .cpu_instr  (cpu_instr),
    .cpu_reset  (cpu_reset),
    .cpu_resume (cpu_resume),
    .led        (led)
  );

  always #20 clk = ~clk;

  task automatic check(input logic [WIDTH_D-1:0] got, input logic [WIDTH_D-1:0] exp,
                       input string msg);
    if (got !== exp)
    begin
      $display("[ERROR] %0t %s: got %h, expected %h", $time, msg, got, exp);
      $display("Errors found");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic add_entry(input logic [3:0] kind, input logic [DEPTH_V-1:0] addr,
                           input logic [WIDTH_D-1:0] data, input logic [WIDTH_D-1:0] exp);
    entry_t e;
    e.kind = kind;
    e.addr = addr;
    e.data = data;
    e.exp = exp;
    table_q.push_back(e);
  endtask

  // random gap first, then a one-cycle strobe and one low cycle
  task automatic send_byte(input logic [7:0] b);
    int gap;
    gap = $unsigned($random(seed)) % 3;
    repeat (gap) @(negedge clk);
    rx_data = b;
    rx_re = 1'b1;
    @(negedge clk);
    rx_re = 1'b0;
    @(negedge clk);
  endtask

  task automatic send_packet(input logic [DEPTH_V-1:0] addr, input logic [WIDTH_D-1:0] data,
                             input logic [7:0] start_b, input logic [7:0] end_b);
    logic [31:0] addr_w;
    addr_w = {{(32 - DEPTH_V){1'b0}}, addr};
    send_byte(start_b);
    for (int i = 0; i < 4; i++)
      send_byte(addr_w[8*i +: 8]);
    for (int i = 0; i < 4; i++)
      send_byte(data[8*i +: 8]);
    send_byte(end_b);
  endtask

  // host write strobe, then one more edge for the commit
  task automatic wait_host_write();
    int cnt;
    logic seen;
    cnt = 0;
    seen = dut_i.host_wr.we;
    while (!seen && cnt < 16)
    begin
      @(negedge clk);
      seen = dut_i.host_wr.we;
      cnt++;
    end
    if (!seen)
    begin
      $display("timeout: the host write strobe never came after a packet");
      $display("Errors found");
      $fatal(1, "timeout");
    end
    @(negedge clk);
  endtask

  task automatic cpu_write(input logic [DEPTH_V-1:0] addr, input logic [WIDTH_D-1:0] data);
    cpu_wr.addr = addr;
    cpu_wr.data = data;
    cpu_wr.we = 1'b1;
    @(negedge clk);
    cpu_wr.we = 1'b0;
  endtask

  initial
  begin
    entry_t cur;
    logic [WIDTH_D-1:0] last_rd;
    arst_n = 1'b0;
    rx_re = 1'b0;
    rx_data = '0;
    cpu_wr = '0;
    cpu_addr_a = '0;
    cpu_addr_b = '0;
    cpu_pc = '0;
    last_rd = '0;

    add_entry(K_SYS, 0, 0, 0);
    add_entry(K_LED, 0, 0, 0);
    // code memory, page 4
    add_entry(K_HOST, 17'h04003, 32'h1234_5678, 0);
    add_entry(K_HOST, 17'h04007, 32'hCAFE_0001, 0);
    add_entry(K_PC, 3, 0, 32'h1234_5678);
    add_entry(K_PC, 7, 0, 32'hCAFE_0001);
    // data memory while the host is master, then hand over
    add_entry(K_HOST, 17'h00010, 32'hA5A5_0010, 0);
    add_entry(K_HOST, 17'h00011, 32'h0BAD_F00D, 0);
    add_entry(K_HOST, 17'h05002, 32'h1, 0);
    add_entry(K_RD_A, 17'h00010, 0, 32'hA5A5_0010);
    add_entry(K_RD_B, 17'h00011, 0, 32'h0BAD_F00D);
    add_entry(K_HOST, 17'h00010, 32'hDEAD_BEEF, 0);
    add_entry(K_RD_A, 17'h00010, 0, 32'hA5A5_0010);
    add_entry(K_RD_B, 17'h00010, 0, 32'hA5A5_0010);
    // expected is {cpu_reset, cpu_resume}
    add_entry(K_HOST, 17'h05000, 32'h1, 0);
    add_entry(K_SYS, 0, 0, 2);
    add_entry(K_HOST, 17'h05001, 32'h1, 0);
    add_entry(K_SYS, 0, 0, 3);
    add_entry(K_BAD_START, 17'h05000, 0, 0);
    add_entry(K_SYS, 0, 0, 3);
    add_entry(K_BAD_END, 17'h05001, 0, 0);
    add_entry(K_SYS, 0, 0, 3);
    add_entry(K_CPU_WR, 17'h03004, 32'h0000_ABCD, 0);
    add_entry(K_LED, 0, 0, 32'h3CD);
    add_entry(K_CPU_WR, 17'h00020, 32'h7654_3210, 0);
    add_entry(K_RD_A, 17'h00020, 0, 32'h7654_3210);
    // timer held, then released
    add_entry(K_CPU_WR, 17'h0300F, 32'h1, 0);
    add_entry(K_IDLE, 0, 4, 0);
    add_entry(K_RD_A, 17'h02004, 0, 0);
    add_entry(K_CPU_WR, 17'h0300F, 32'h0, 0);
    add_entry(K_IDLE, 0, 3, 0);
    add_entry(K_TIMER, 17'h02004, 0, 0);
    add_entry(K_IDLE, 0, 6, 0);
    add_entry(K_TIMER, 17'h02004, 0, 0);

    repeat (8) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);

    for (int i = 0; i < table_q.size(); i++)
    begin
      cur = table_q[i];
      case (cur.kind)
        K_HOST:
        begin
          send_packet(cur.addr, cur.data, PKT_START, PKT_END);
          wait_host_write();
        end
        K_BAD_START:
        begin
          send_packet(cur.addr, cur.data, 8'h00, PKT_END);
          repeat (4) @(negedge clk);
        end
        K_BAD_END:
        begin
          send_packet(cur.addr, cur.data, PKT_START, 8'h00);
          repeat (4) @(negedge clk);
        end
        K_CPU_WR:
          cpu_write(cur.addr, cur.data);
        K_RD_A:
        begin
          cpu_addr_a = cur.addr;
          @(negedge clk);
          check(cpu_rd_a, cur.exp, "read port a");
          last_rd = cpu_rd_a;
        end
        K_RD_B:
        begin
          cpu_addr_b = cur.addr;
          @(negedge clk);
          check(cpu_rd_b, cur.exp, "read port b");
        end
        K_PC:
        begin
          cpu_pc = cur.addr[DEPTH_I-1:0];
          @(negedge clk);
          check(cpu_instr, cur.exp, "instruction fetch");
        end
        K_SYS:
          check({30'b0, cpu_reset, cpu_resume}, cur.exp, "cpu reset and resume");
        K_LED:
        begin
          @(negedge clk);
          check({22'b0, led}, cur.exp, "led output");
        end
        K_TIMER:
        begin
          cpu_addr_a = cur.addr;
          @(negedge clk);
          check({31'b0, cpu_rd_a > last_rd}, 32'h1, "timer count not increasing");
          last_rd = cpu_rd_a;
        end
        default:
          repeat (cur.data[3:0]) @(negedge clk);
      endcase
    end

    $display("No errors");
    $finish;
  end

endmodule

// File: rtl/soc_top.sv
/* SoC fabric without the processor core; the processor buses are ports
   DEPTH_I and DEPTH_D must not exceed PAGE_BITS */
module soc_top #(
  parameter int DEPTH_I = 12,
  parameter int DEPTH_D = 12
) (
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic                         rx_re,
  input  logic [7:0]                   rx_data,
  input  soc_pkg::bus_wr_t             cpu_wr,
  input  logic [soc_pkg::DEPTH_V-1:0]  cpu_addr_a,
  input  logic [soc_pkg::DEPTH_V-1:0]  cpu_addr_b,
  input  logic [DEPTH_I-1:0]           cpu_pc,
  output logic [soc_pkg::WIDTH_D-1:0]  cpu_rd_a,
  output logic [soc_pkg::WIDTH_D-1:0]  cpu_rd_b,
  output logic [soc_pkg::WIDTH_I-1:0]  cpu_instr,
  output logic                         cpu_reset,
  output logic                         cpu_resume,
  output logic [soc_pkg::LED_BITS-1:0] led
);
  import soc_pkg::*;

  bus_wr_t            host_wr;
  bus_wr_t            dmem_wr;
  bus_wr_t            imem_wr;
  logic               io_we;
  logic [DEPTH_V-1:0] dmem_addr_a;
  logic [WIDTH_D-1:0] dmem_rd_a;
  logic [WIDTH_D-1:0] io_rd;

  host_packet_rx rx_i (
    .clk     (clk),
    .arst_n  (arst_n),
    .rx_re   (rx_re),
    .rx_data (rx_data),
    .host_wr (host_wr)
  );

  soc_ctrl ctrl_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .host_wr     (host_wr),
    .cpu_wr      (cpu_wr),
    .cpu_addr_a  (cpu_addr_a),
    .dmem_rd_a   (dmem_rd_a),
    .io_rd       (io_rd),
    .dmem_wr     (dmem_wr),
    .dmem_addr_a (dmem_addr_a),
    .imem_wr     (imem_wr),
    .io_we       (io_we),
    .cpu_rd_a    (cpu_rd_a),
    .cpu_reset   (cpu_reset),
    .cpu_resume  (cpu_resume)
  );

  data_mem #(
    .DEPTH_D (DEPTH_D)
  ) dmem_i (
    .clk    (clk),
    .wr     (dmem_wr),
    .addr_a (dmem_addr_a),
    .addr_b (cpu_addr_b),
    .rd_a   (dmem_rd_a),
    .rd_b   (cpu_rd_b)
  );

  code_mem #(
    .DEPTH_I (DEPTH_I)
  ) imem_i (
    .clk  (clk),
    .wr   (imem_wr),
    .addr (cpu_pc),
    .rd   (cpu_instr)
  );

  io_regs io_i (
    .clk     (clk),
    .arst_n  (arst_n),
    .we      (io_we),
    .wr_addr (cpu_wr.addr[IO_REG_BITS-1:0]),
    .wr_data (cpu_wr.data),
    .rd_addr (cpu_addr_a[IO_REG_BITS-1:0]),
    .rd_data (io_rd),
    .led     (led)
  );

endmodule

// File: rtl/io_regs.sv
/* i/o registers: LED and timer reset on the write side, timer count on the read side
   unkept indices write nowhere and read as zero */
module io_regs (
  input  logic                            clk,
  input  logic                            arst_n,
  input  logic                            we,
  input  logic [soc_pkg::IO_REG_BITS-1:0] wr_addr,
  input  logic [soc_pkg::WIDTH_D-1:0]     wr_data,
  input  logic [soc_pkg::IO_REG_BITS-1:0] rd_addr,
  output logic [soc_pkg::WIDTH_D-1:0]     rd_data,
  output logic [soc_pkg::LED_BITS-1:0]    led
);
  import soc_pkg::*;

  logic [LED_BITS-1:0] led_reg;
  logic [WIDTH_D-1:0]  timer_rst_reg;
  logic [WIDTH_D-1:0]  timer;
  logic [WIDTH_D-1:0]  timer_sample;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      led_reg <= '0;
      timer_rst_reg <= '0;
    end
    else if (we)
    begin
      case (wr_addr)
        IO_W_LED:
          led_reg <= wr_data[LED_BITS-1:0];
        IO_W_TIMER_RESET:
          timer_rst_reg <= wr_data;
        default: ;
      endcase
    end
  end

  // free-running, held at zero while timer reset is nonzero
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      timer <= '0;
    else if (timer_rst_reg != '0)
      timer <= '0;
    else
      timer <= timer + 1'b1;
  end

  // read register 4 and the addressed copy
  always_ff @(posedge clk)
  begin
    timer_sample <= timer;
    if (rd_addr == IO_R_TIMER_COUNT)
      rd_data <= timer_sample;
    else
      rd_data <= '0;
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      led <= '0;
    else
      led <= led_reg;
  end

endmodule

// File: rtl/code_mem.sv
/* code memory, 2**DEPTH_I words; host writes by word address, processor reads by pc */
module code_mem #(
  parameter int DEPTH_I = 12
) (
  input  logic                        clk,
  input  soc_pkg::bus_wr_t            wr,
  input  logic [DEPTH_I-1:0]          addr,
  output logic [soc_pkg::WIDTH_I-1:0] rd
);
  import soc_pkg::*;

  logic [WIDTH_I-1:0] mem [0:(1 << DEPTH_I)-1];

  always_ff @(posedge clk)
  begin
    if (wr.we)
      mem[wr.addr[DEPTH_I-1:0]] <= wr.data;
  end

  // instruction fetch, one cycle after pc
  always_ff @(posedge clk)
  begin
    rd <= mem[addr];
  end

endmodule

// File: rtl/data_mem.sv
/* data memory, 2**DEPTH_D words, two registered read ports and one write port
   upper address bits are ignored, so the page offset wraps */
module data_mem #(
  parameter int DEPTH_D = 12
) (
  input  logic                        clk,
  input  soc_pkg::bus_wr_t            wr,
  input  logic [soc_pkg::DEPTH_V-1:0] addr_a,
  input  logic [soc_pkg::DEPTH_V-1:0] addr_b,
  output logic [soc_pkg::WIDTH_D-1:0] rd_a,
  output logic [soc_pkg::WIDTH_D-1:0] rd_b
);
  import soc_pkg::*;

  logic [WIDTH_D-1:0] mem [0:(1 << DEPTH_D)-1];

  always_ff @(posedge clk)
  begin
    if (wr.we)
      mem[wr.addr[DEPTH_D-1:0]] <= wr.data;
  end

  // read before write on a shared address
  always_ff @(posedge clk)
  begin
    rd_a <= mem[addr_a[DEPTH_D-1:0]];
    rd_b <= mem[addr_b[DEPTH_D-1:0]];
  end

  a_wr_addr_known: assert property (@(posedge clk)
    wr.we |-> !$isunknown(wr.addr[DEPTH_D-1:0]));

endmodule

// File: rtl/soc_ctrl.sv
/* address decode, data-memory master switch and system registers
   host owns code memory and system registers; reads of other regions return zero */
module soc_ctrl (
  input  logic                        clk,
  input  logic                        arst_n,
  input  soc_pkg::bus_wr_t            host_wr,
  input  soc_pkg::bus_wr_t            cpu_wr,
  input  logic [soc_pkg::DEPTH_V-1:0] cpu_addr_a,
  input  logic [soc_pkg::WIDTH_D-1:0] dmem_rd_a,
  input  logic [soc_pkg::WIDTH_D-1:0] io_rd,
  output soc_pkg::bus_wr_t            dmem_wr,
  output logic [soc_pkg::DEPTH_V-1:0] dmem_addr_a,
  output soc_pkg::bus_wr_t            imem_wr,
  output logic                        io_we,
  output logic [soc_pkg::WIDTH_D-1:0] cpu_rd_a,
  output logic                        cpu_reset,
  output logic                        cpu_resume
);
  import soc_pkg::*;

  map_region_t region_host;
  map_region_t region_cpu_w;
  map_region_t region_a;
  map_region_t region_a_q;
  master_t     master_d;
  logic        host_owns_d;
  logic        cpu_owns_d;
  logic        sys_we;

  assign region_host = map_region(host_wr.addr);
  assign region_cpu_w = map_region(cpu_wr.addr);
  assign region_a = map_region(cpu_addr_a);

  assign host_owns_d = (master_d == MASTER_SOC) && (region_host == MAP_MEM_D);
  assign cpu_owns_d = (master_d == MASTER_CPU) && (region_cpu_w == MAP_MEM_D);
  assign sys_we = host_wr.we && (region_host == MAP_SYS);

  // data memory write port follows the current master
  always_comb
  begin
    if (host_owns_d)
      dmem_wr = host_wr;
    else if (cpu_owns_d)
      dmem_wr = cpu_wr;
    else
      dmem_wr = '0;
  end

  always_comb
  begin
    imem_wr = host_wr;
    imem_wr.we = host_wr.we && (region_host == MAP_MEM_I);
    io_we = cpu_wr.we && (region_cpu_w == MAP_REG_W);
  end

  assign dmem_addr_a = ((master_d == MASTER_CPU) && (region_a == MAP_MEM_D)) ? cpu_addr_a : '0;

  // region of the read in flight on port a
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      region_a_q <= MAP_NONE;
    else
      region_a_q <= region_a;
  end

  always_comb
  begin
    case (region_a_q)
      MAP_MEM_D:
        cpu_rd_a = (master_d == MASTER_CPU) ? dmem_rd_a : '0;
      MAP_REG_R:
        cpu_rd_a = io_rd;
      default:
        cpu_rd_a = '0;
    endcase
  end

  // only bit 0 of each system register is kept
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      cpu_reset <= 1'b0;
      cpu_resume <= 1'b0;
      master_d <= MASTER_SOC;
    end
    else if (sys_we)
    begin
      case (host_wr.addr[SYS_REG_BITS-1:0])
        SYS_CPU_RESET:
          cpu_reset <= host_wr.data[0];
        SYS_CPU_RESUME:
          cpu_resume <= host_wr.data[0];
        SYS_MASTER_OF_MEM_D:
          master_d <= master_t'(host_wr.data[0]);
        default: ;
      endcase
    end
  end

  // a data-memory write lands in page 0 and carries the strobe of the current master only
  a_one_dmem_master: assert property (@(posedge clk) disable iff (!arst_n)
    dmem_wr.we |-> (dmem_wr.addr[DEPTH_V-1:PAGE_BITS] == '0) &&
      ((master_d == MASTER_SOC) ? host_wr.we : cpu_wr.we));

  a_we_known: assert property (@(posedge clk) disable iff (!arst_n)
    !$isunknown({dmem_wr.we, imem_wr.we, io_we}));

endmodule

// File: rtl/host_packet_rx.sv
/* ten-byte host packet: start, addr[4], data[4], end, least significant byte first
   address bits above DEPTH_V are dropped; bytes arrive as rx_re pulses, no flow control */
module host_packet_rx (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             rx_re,
  input  logic [7:0]       rx_data,
  output soc_pkg::bus_wr_t host_wr
);
  import soc_pkg::*;

  logic               rx_re_d1;
  logic               rx_rise;
  logic [3:0]         byte_cnt;
  logic               pkt_done;
  logic [7:0]         pkt_q [1:8];
  logic [31:0]        pkt_addr;
  logic [WIDTH_D-1:0] pkt_data;
  logic               host_we_q;
  logic [DEPTH_V-1:0] host_addr_q;
  logic [WIDTH_D-1:0] host_data_q;

  // rising edge of the byte strobe
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      rx_re_d1 <= 1'b0;
    else
      rx_re_d1 <= rx_re;
  end

  assign rx_rise = rx_re && !rx_re_d1;

  // byte counter, waits in 0 until a start byte
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      byte_cnt <= 4'd0;
      pkt_done <= 1'b0;
    end
    else
    begin
      pkt_done <= 1'b0;
      if (rx_rise)
      begin
        case (byte_cnt)
          4'd0:
          begin
            if (rx_data == PKT_START)
              byte_cnt <= 4'd1;
          end
          4'd9:
          begin
            byte_cnt <= 4'd0;
            pkt_done <= (rx_data == PKT_END);
          end
          default:
            byte_cnt <= byte_cnt + 4'd1;
        endcase
      end
    end
  end

  // payload bytes 1..8
  always_ff @(posedge clk)
  begin
    if (rx_rise && (byte_cnt >= 4'd1) && (byte_cnt <= 4'd8))
      pkt_q[byte_cnt] <= rx_data;
  end

  assign pkt_addr = {pkt_q[4], pkt_q[3], pkt_q[2], pkt_q[1]};
  assign pkt_data = {pkt_q[8], pkt_q[7], pkt_q[6], pkt_q[5]};

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      host_we_q <= 1'b0;
    else
      host_we_q <= pkt_done;
  end

  always_ff @(posedge clk)
  begin
    if (pkt_done)
    begin
      host_addr_q <= pkt_addr[DEPTH_V-1:0];
      host_data_q <= pkt_data;
    end
  end

  assign host_wr = '{addr: host_addr_q, data: host_data_q, we: host_we_q};

  a_cnt_range: assert property (@(posedge clk) disable iff (!arst_n)
    byte_cnt < 4'd10);

endmodule

// File: rtl/soc_pkg.sv
/* fabric constants, bus types and page decode
   page size is 2**PAGE_BITS words; DEPTH_I and DEPTH_D must not exceed PAGE_BITS */
package soc_pkg;

  // word widths
  localparam int WIDTH_D = 32;
  localparam int WIDTH_I = 32;

  // address layout: page number above, offset below
  localparam int DEPTH_V = 17;
  localparam int PAGE_BITS = 12;
  localparam int MAP_BITS = DEPTH_V - PAGE_BITS;

  typedef enum logic [2:0] {
    MAP_MEM_D = 3'd0,
    MAP_NONE  = 3'd1,
    MAP_REG_R = 3'd2,
    MAP_REG_W = 3'd3,
    MAP_MEM_I = 3'd4,
    MAP_SYS   = 3'd5
  } map_region_t;

  // i/o register indices
  localparam int IO_REG_BITS = 5;
  localparam logic [IO_REG_BITS-1:0] IO_W_LED = 5'd4;
  localparam logic [IO_REG_BITS-1:0] IO_W_TIMER_RESET = 5'd15;
  localparam logic [IO_REG_BITS-1:0] IO_R_TIMER_COUNT = 5'd4;

  // system register indices
  localparam int SYS_REG_BITS = 4;
  localparam logic [SYS_REG_BITS-1:0] SYS_CPU_RESET = 4'd0;
  localparam logic [SYS_REG_BITS-1:0] SYS_CPU_RESUME = 4'd1;
  localparam logic [SYS_REG_BITS-1:0] SYS_MASTER_OF_MEM_D = 4'd2;

  typedef enum logic {
    MASTER_SOC = 1'b0,
    MASTER_CPU = 1'b1
  } master_t;

  // host packet framing
  localparam logic [7:0] PKT_START = 8'hAA;
  localparam logic [7:0] PKT_END = 8'h55;

  localparam int LED_BITS = 10;

  // one write cycle, we is a single-cycle strobe
  typedef struct packed {
    logic [DEPTH_V-1:0] addr;
    logic [WIDTH_D-1:0] data;
    logic               we;
  } bus_wr_t;

  // page number to region, unmapped pages fall into NONE
  function automatic map_region_t map_region(input logic [DEPTH_V-1:0] addr);
    logic [MAP_BITS-1:0] page;
    page = addr[DEPTH_V-1:PAGE_BITS];
    case (page)
      0:
        return MAP_MEM_D;
      2:
        return MAP_REG_R;
      3:
        return MAP_REG_W;
      4:
        return MAP_MEM_I;
      5:
        return MAP_SYS;
      default:
        return MAP_NONE;
    endcase
  endfunction

endpackage
